// ==== verilog/mac_ctrl_pkg.sv ====
// Frame constants, widths, opcode and state enums for the MAC control sublayer
package mac_ctrl_pkg;

    localparam int WORD_W = 32;
    localparam int MCF_WORDS = 15;  // 60 bytes without FCS
    localparam int QUANTA_W = 16;

    localparam logic [47:0] MCF_DST = 48'h01_80_C2_00_00_01;
    localparam logic [15:0] MCF_ETH_TYPE = 16'h8808;

    typedef enum logic [15:0] {
        OPC_LFC = 16'h0001,
        OPC_PFC = 16'h0101  // Recognised only so it can be rejected
    } mcf_opcode_t;

    typedef enum logic [1:0] {
        MUX_IDLE,
        MUX_DATA,
        MUX_MCF
    } mux_state_t;

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_XOFF_PEND,
        GEN_ON,
        GEN_XON_PEND
    } gen_state_t;

    // One pause quantum is 512 bit times
    function automatic int quanta_cycles(int data_w);
        return 512 / data_w;
    endfunction

endpackage

// ==== verilog/mcf_rx_parser.sv ====
// Receive control frame match, 4-cycle delay line with frame drop, and quanta capture
`timescale 1ns/1ps

module mcf_rx_parser (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic [mac_ctrl_pkg::WORD_W-1:0]   rx_data,
    input  wire logic                              rx_valid,
    input  wire logic                              rx_last,
    input  wire logic                              cfg_mcf_rx_forward,
    output wire logic [mac_ctrl_pkg::WORD_W-1:0]   m_rx_data,
    output wire logic                              m_rx_valid,
    output wire logic                              m_rx_last,
    output logic                                   rx_mcf_strobe,
    output logic [mac_ctrl_pkg::QUANTA_W-1:0]      rx_mcf_quanta,
    output wire logic                              stat_rx_mcf
);

    logic [2:0]                      pos;          // Word index, saturates at 5
    logic                            hdr_ok;       // Words 0 and 1 matched so far
    logic                            mcf_hit;      // Words 0 to 3 matched
    logic                            drop_frame;
    logic                            word3_match;
    logic                            frame_match;
    logic [mac_ctrl_pkg::WORD_W-1:0] dly_data [4];
    logic [3:0]                      dly_valid;
    logic [3:0]                      dly_last;

    assign word3_match = hdr_ok &&
        rx_data == {mac_ctrl_pkg::MCF_ETH_TYPE, mac_ctrl_pkg::OPC_LFC};

    // Needs at least 4 words, word 3 itself may be the last one
    assign frame_match = (pos == 3'd3) ? word3_match : (pos > 3'd3) && mcf_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos           <= '0;
            hdr_ok        <= 1'b0;
            mcf_hit       <= 1'b0;
            drop_frame    <= 1'b0;
            rx_mcf_strobe <= 1'b0;
        end else begin
            rx_mcf_strobe <= rx_valid && rx_last && frame_match;
            if (rx_valid) begin
                case (pos)
                    3'd0: begin
                        hdr_ok  <= rx_data == mac_ctrl_pkg::MCF_DST[47:16];
                        mcf_hit <= 1'b0;
                    end
                    3'd1: hdr_ok <= hdr_ok && rx_data[31:16] == mac_ctrl_pkg::MCF_DST[15:0];
                    3'd3: mcf_hit <= word3_match;
                    default: ;
                endcase
                if (rx_last)
                    pos <= '0;
                else if (pos != 3'd5)
                    pos <= pos + 3'd1;
            end
            // Decision lands as word 0 reaches the output; a new frame wins over the clear
            if (rx_valid && pos == 3'd3 && word3_match && !cfg_mcf_rx_forward)
                drop_frame <= 1'b1;
            else if (dly_valid[3] && dly_last[3])
                drop_frame <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && pos == 3'd4)
            rx_mcf_quanta <= rx_data[31:16];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dly_valid <= '0;
            dly_last  <= '0;
        end else begin
            dly_valid <= {dly_valid[2:0], rx_valid};
            dly_last  <= {dly_last[2:0], rx_valid && rx_last};
        end
    end

    always_ff @(posedge clk) begin
        dly_data[0] <= rx_data;
        for (int i = 1; i < 4; i++)
            dly_data[i] <= dly_data[i-1];
    end

    assign m_rx_data   = dly_data[3];
    assign m_rx_valid  = dly_valid[3] && !drop_frame;
    assign m_rx_last   = dly_last[3];
    assign stat_rx_mcf = rx_mcf_strobe;

    // Receive stream has no ready, so a frame arrives without gaps
    assert property (@(posedge clk) disable iff (!rst_n) pos != 3'd0 |-> rx_valid)
        else $error("rx_valid dropped inside a frame");

endmodule

// ==== verilog/lfc_rx_timer.sv ====
// Receive pause countdown scaled to clock cycles, drives rx_lfc_req
`timescale 1ns/1ps

module lfc_rx_timer #(
    parameter int DATA_W = 32
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              rx_mcf_strobe,
    input  wire logic [mac_ctrl_pkg::QUANTA_W-1:0] rx_mcf_quanta,
    input  wire logic                              cfg_rx_lfc_en,
    output wire logic                              rx_lfc_req
);

    localparam int QC    = mac_ctrl_pkg::quanta_cycles(DATA_W);
    localparam int CNT_W = mac_ctrl_pkg::QUANTA_W + $clog2(QC);

    logic [CNT_W-1:0] pause_cnt;  // Remaining paused cycles

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pause_cnt <= '0;
        end else if (rx_mcf_strobe && cfg_rx_lfc_en) begin
            // Reload on every frame, zero quanta ends the pause
            pause_cnt <= CNT_W'(rx_mcf_quanta) * CNT_W'(QC);
        end else if (pause_cnt != '0) begin
            pause_cnt <= pause_cnt - 1'b1;
        end
    end

    assign rx_lfc_req = pause_cnt != '0;

endmodule

// ==== verilog/lfc_tx_gen.sv ====
// Pause frame request FSM with XOFF on rising request, refresh timer and XON on release
`timescale 1ns/1ps

module lfc_tx_gen (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              tx_lfc_req,
    input  wire logic                              cfg_tx_lfc_en,
    input  wire logic [mac_ctrl_pkg::QUANTA_W-1:0] cfg_tx_lfc_quanta,
    input  wire logic [mac_ctrl_pkg::QUANTA_W-1:0] cfg_tx_lfc_refresh,
    input  wire logic                              gen_mcf_ready,
    output wire logic                              gen_mcf_valid,
    output wire logic [mac_ctrl_pkg::QUANTA_W-1:0] gen_mcf_quanta,
    output wire logic                              stat_tx_lfc_xon,
    output wire logic                              stat_tx_lfc_xoff
);

    localparam int QC    = mac_ctrl_pkg::quanta_cycles(mac_ctrl_pkg::WORD_W);
    localparam int CNT_W = mac_ctrl_pkg::QUANTA_W + $clog2(QC);

    mac_ctrl_pkg::gen_state_t        state;
    logic                            req_d;
    logic [CNT_W-1:0]                refresh_cnt;
    logic [mac_ctrl_pkg::QUANTA_W-1:0] quanta_q;
    logic                            req_rise;

    assign req_rise      = tx_lfc_req && !req_d;
    assign gen_mcf_valid = state == mac_ctrl_pkg::GEN_XOFF_PEND ||
                           state == mac_ctrl_pkg::GEN_XON_PEND;
    assign gen_mcf_quanta = quanta_q;

    assign stat_tx_lfc_xoff = state == mac_ctrl_pkg::GEN_XOFF_PEND && gen_mcf_ready;
    assign stat_tx_lfc_xon  = state == mac_ctrl_pkg::GEN_XON_PEND && gen_mcf_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= mac_ctrl_pkg::GEN_IDLE;
            req_d       <= 1'b0;
            refresh_cnt <= '0;
        end else begin
            req_d <= tx_lfc_req;
            case (state)
                mac_ctrl_pkg::GEN_IDLE:
                    if (req_rise && cfg_tx_lfc_en)
                        state <= mac_ctrl_pkg::GEN_XOFF_PEND;
                mac_ctrl_pkg::GEN_XOFF_PEND:
                    if (gen_mcf_ready) begin
                        state       <= mac_ctrl_pkg::GEN_ON;
                        refresh_cnt <= CNT_W'(cfg_tx_lfc_refresh) * CNT_W'(QC);
                    end
                mac_ctrl_pkg::GEN_ON:
                    if (!tx_lfc_req)
                        state <= mac_ctrl_pkg::GEN_XON_PEND;
                    else if (refresh_cnt <= CNT_W'(2))  // Next XOFF valid N cycles on
                        state <= mac_ctrl_pkg::GEN_XOFF_PEND;
                    else
                        refresh_cnt <= refresh_cnt - 1'b1;
                mac_ctrl_pkg::GEN_XON_PEND:
                    // A request raised while XON waited is not lost
                    if (gen_mcf_ready)
                        state <= (tx_lfc_req && cfg_tx_lfc_en) ? mac_ctrl_pkg::GEN_XOFF_PEND
                                                               : mac_ctrl_pkg::GEN_IDLE;
                default: state <= mac_ctrl_pkg::GEN_IDLE;
            endcase
        end
    end

    // Quanta follows config until a request is pending
    always_ff @(posedge clk) begin
        if (!gen_mcf_valid || gen_mcf_ready)
            quanta_q <= (state == mac_ctrl_pkg::GEN_ON && !tx_lfc_req) ? '0 : cfg_tx_lfc_quanta;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        gen_mcf_valid && !gen_mcf_ready |=> gen_mcf_valid && $stable(gen_mcf_quanta))
        else $error("pause request changed before acceptance");

endmodule

// ==== verilog/mcf_tx_mux.sv ====
// Transmit merge of pause frames into the user stream, with receive pause hold
`timescale 1ns/1ps

module mcf_tx_mux #(
    parameter logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_01
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic [mac_ctrl_pkg::WORD_W-1:0]   s_tx_data,
    input  wire logic                              s_tx_valid,
    input  wire logic                              s_tx_last,
    output wire logic                              s_tx_ready,
    output wire logic [mac_ctrl_pkg::WORD_W-1:0]   m_tx_data,
    output wire logic                              m_tx_valid,
    output wire logic                              m_tx_last,
    input  wire logic                              m_tx_ready,
    input  wire logic                              gen_mcf_valid,
    output wire logic                              gen_mcf_ready,
    input  wire logic [mac_ctrl_pkg::QUANTA_W-1:0] gen_mcf_quanta,
    input  wire logic                              rx_lfc_req,
    input  wire logic                              lfc_pause_en,
    output wire logic                              tx_pause_ack,
    output wire logic                              stat_tx_mcf
);

    mac_ctrl_pkg::mux_state_t          state;
    logic [3:0]                        word_cnt;
    logic [mac_ctrl_pkg::QUANTA_W-1:0] quanta_q;
    logic [mac_ctrl_pkg::WORD_W-1:0]   mcf_word;
    logic                              pause;
    logic                              data_sel;

    assign pause    = rx_lfc_req && lfc_pause_en;
    // Pending control frame wins, pause only blocks the start of a data frame
    assign data_sel = state == mac_ctrl_pkg::MUX_DATA ||
                      (state == mac_ctrl_pkg::MUX_IDLE && !gen_mcf_valid && !pause);

    assign gen_mcf_ready = state == mac_ctrl_pkg::MUX_IDLE;
    assign tx_pause_ack  = state == mac_ctrl_pkg::MUX_IDLE && pause;

    always_comb begin
        case (word_cnt)
            4'd0:    mcf_word = mac_ctrl_pkg::MCF_DST[47:16];
            4'd1:    mcf_word = {mac_ctrl_pkg::MCF_DST[15:0], LOCAL_MAC[47:32]};
            4'd2:    mcf_word = LOCAL_MAC[31:0];
            4'd3:    mcf_word = {mac_ctrl_pkg::MCF_ETH_TYPE, mac_ctrl_pkg::OPC_LFC};
            4'd4:    mcf_word = {quanta_q, 16'h0000};
            default: mcf_word = '0;  // Padding up to 60 bytes
        endcase
    end

    assign m_tx_valid = data_sel ? s_tx_valid : state == mac_ctrl_pkg::MUX_MCF;
    assign m_tx_data  = data_sel ? s_tx_data : mcf_word;
    assign m_tx_last  = data_sel ? s_tx_last : word_cnt == 4'(mac_ctrl_pkg::MCF_WORDS - 1);
    assign s_tx_ready = data_sel && s_tx_valid && m_tx_ready;
    assign stat_tx_mcf = state == mac_ctrl_pkg::MUX_MCF && m_tx_ready && m_tx_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= mac_ctrl_pkg::MUX_IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                mac_ctrl_pkg::MUX_IDLE:
                    if (gen_mcf_valid) begin
                        state    <= mac_ctrl_pkg::MUX_MCF;
                        word_cnt <= '0;
                    end else if (data_sel && s_tx_valid && !(m_tx_ready && s_tx_last)) begin
                        state <= mac_ctrl_pkg::MUX_DATA;  // Committed once a beat is shown
                    end
                mac_ctrl_pkg::MUX_DATA:
                    if (s_tx_valid && m_tx_ready && s_tx_last)
                        state <= mac_ctrl_pkg::MUX_IDLE;
                mac_ctrl_pkg::MUX_MCF:
                    if (m_tx_ready) begin
                        word_cnt <= word_cnt + 4'd1;
                        if (m_tx_last)
                            state <= mac_ctrl_pkg::MUX_IDLE;
                    end
                default: state <= mac_ctrl_pkg::MUX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (gen_mcf_valid && gen_mcf_ready)
            quanta_q <= gen_mcf_quanta;
    end

    // Holds across data and control frames alike
    assert property (@(posedge clk) disable iff (!rst_n)
        m_tx_valid && !m_tx_ready |=> m_tx_valid && $stable(m_tx_data))
        else $error("m_tx beat withdrawn before transfer");

endmodule

// ==== verilog/mac_ctrl_top.sv ====
// MAC control top level with receive parser, pause timer, pause generator and transmit mux
`timescale 1ns/1ps

module mac_ctrl_top #(
    parameter int          DATA_W    = 32,
    parameter logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_01
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,

    input  wire logic [mac_ctrl_pkg::WORD_W-1:0]     s_tx_data,
    input  wire logic                                s_tx_valid,
    input  wire logic                                s_tx_last,
    output wire logic                                s_tx_ready,

    output wire logic [mac_ctrl_pkg::WORD_W-1:0]     m_tx_data,
    output wire logic                                m_tx_valid,
    output wire logic                                m_tx_last,
    input  wire logic                                m_tx_ready,

    input  wire logic [mac_ctrl_pkg::WORD_W-1:0]     rx_data,
    input  wire logic                                rx_valid,
    input  wire logic                                rx_last,

    output wire logic [mac_ctrl_pkg::WORD_W-1:0]     m_rx_data,
    output wire logic                                m_rx_valid,
    output wire logic                                m_rx_last,

    input  wire logic                                tx_lfc_req,
    input  wire logic                                lfc_pause_en,
    input  wire logic                                cfg_tx_lfc_en,
    input  wire logic [mac_ctrl_pkg::QUANTA_W-1:0]   cfg_tx_lfc_quanta,
    input  wire logic [mac_ctrl_pkg::QUANTA_W-1:0]   cfg_tx_lfc_refresh,
    input  wire logic                                cfg_rx_lfc_en,
    input  wire logic                                cfg_mcf_rx_forward,

    output wire logic                                rx_lfc_req,
    output wire logic                                tx_pause_ack,
    output wire logic                                stat_tx_mcf,
    output wire logic                                stat_tx_lfc_xon,
    output wire logic                                stat_tx_lfc_xoff,
    output wire logic                                stat_rx_mcf
);

    wire logic                              gen_mcf_valid;
    wire logic                              gen_mcf_ready;
    wire logic [mac_ctrl_pkg::QUANTA_W-1:0] gen_mcf_quanta;
    wire logic                              rx_mcf_strobe;
    wire logic [mac_ctrl_pkg::QUANTA_W-1:0] rx_mcf_quanta;

    mcf_rx_parser i_mcf_rx_parser (
        .clk                (clk),
        .rst_n              (rst_n),
        .rx_data            (rx_data),
        .rx_valid           (rx_valid),
        .rx_last            (rx_last),
        .cfg_mcf_rx_forward (cfg_mcf_rx_forward),
        .m_rx_data          (m_rx_data),
        .m_rx_valid         (m_rx_valid),
        .m_rx_last          (m_rx_last),
        .rx_mcf_strobe      (rx_mcf_strobe),
        .rx_mcf_quanta      (rx_mcf_quanta),
        .stat_rx_mcf        (stat_rx_mcf)
    );

    // Received pause time, fed back into the transmit hold
    lfc_rx_timer #(
        .DATA_W (DATA_W)
    ) i_lfc_rx_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_mcf_strobe (rx_mcf_strobe),
        .rx_mcf_quanta (rx_mcf_quanta),
        .cfg_rx_lfc_en (cfg_rx_lfc_en),
        .rx_lfc_req    (rx_lfc_req)
    );

    lfc_tx_gen i_lfc_tx_gen (
        .clk                (clk),
        .rst_n              (rst_n),
        .tx_lfc_req         (tx_lfc_req),
        .cfg_tx_lfc_en      (cfg_tx_lfc_en),
        .cfg_tx_lfc_quanta  (cfg_tx_lfc_quanta),
        .cfg_tx_lfc_refresh (cfg_tx_lfc_refresh),
        .gen_mcf_ready      (gen_mcf_ready),
        .gen_mcf_valid      (gen_mcf_valid),
        .gen_mcf_quanta     (gen_mcf_quanta),
        .stat_tx_lfc_xon    (stat_tx_lfc_xon),
        .stat_tx_lfc_xoff   (stat_tx_lfc_xoff)
    );

    mcf_tx_mux #(
        .LOCAL_MAC (LOCAL_MAC)
    ) i_mcf_tx_mux (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_tx_data      (s_tx_data),
        .s_tx_valid     (s_tx_valid),
        .s_tx_last      (s_tx_last),
        .s_tx_ready     (s_tx_ready),
        .m_tx_data      (m_tx_data),
        .m_tx_valid     (m_tx_valid),
        .m_tx_last      (m_tx_last),
        .m_tx_ready     (m_tx_ready),
        .gen_mcf_valid  (gen_mcf_valid),
        .gen_mcf_ready  (gen_mcf_ready),
        .gen_mcf_quanta (gen_mcf_quanta),
        .rx_lfc_req     (rx_lfc_req),
        .lfc_pause_en   (lfc_pause_en),
        .tx_pause_ack   (tx_pause_ack),
        .stat_tx_mcf    (stat_tx_mcf)
    );

endmodule

// ==== tests/mac_ctrl_checker.sv ====
// Monitor comparing transmit and receive streams, pause timing and strobe counts with expectations
`timescale 1ns/1ps

module mac_ctrl_checker (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic [31:0] m_tx_data,
    input wire logic        m_tx_valid,
    input wire logic        m_tx_last,
    input wire logic        m_tx_ready,
    input wire logic        s_tx_ready,
    input wire logic [31:0] m_rx_data,
    input wire logic        m_rx_valid,
    input wire logic        m_rx_last,
    input wire logic        rx_lfc_req,
    input wire logic        tx_pause_ack,
    input wire logic        stat_tx_mcf,
    input wire logic        stat_tx_lfc_xon,
    input wire logic        stat_tx_lfc_xoff,
    input wire logic        stat_rx_mcf
);

    logic [32:0] data_q[$];    // {last, word} per expected beat
    logic [32:0] mcf_q[$];
    logic [32:0] rx_q[$];
    int          rx_cyc_q[$];  // Cycle each m_rx beat is due
    int          cyc = 0;
    int          errors = 0;
    int          p_start = 0;
    int          p_end = 0;
    int          n_start = 0;
    int          n_end = 0;
    bit          n_pend = 0;
    bit          hold_en = 0;  // Transmit must be held by the pause
    bit          in_frame = 0;
    bit          in_mcf = 0;
    int          cnt[4] = '{0, 0, 0, 0};  // xoff, xon, tx mcf, rx mcf

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic expect_tx(input bit is_mcf, input logic [32:0] beat);
        if (is_mcf)
            mcf_q.push_back(beat);
        else
            data_q.push_back(beat);
    endtask

    task automatic expect_rx(input logic [32:0] beat);
        rx_q.push_back(beat);
        rx_cyc_q.push_back(cyc + 4);
    endtask

    // New window starts two cycles after the last beat is driven
    task automatic expect_pause(input int len);
        n_start = cyc + 2;
        n_end   = cyc + 2 + len;
        n_pend  = 1;
    endtask

    task automatic expect_counts(input int xoff, input int xon, input int tx_mcf, input int rx_mcf);
        compare("stat_tx_lfc_xoff count", xoff, cnt[0]);
        compare("stat_tx_lfc_xon count", xon, cnt[1]);
        compare("stat_tx_mcf count", tx_mcf, cnt[2]);
        compare("stat_rx_mcf count", rx_mcf, cnt[3]);
        cnt = '{0, 0, 0, 0};
    endtask

    function automatic int mcf_left();
        return mcf_q.size();
    endfunction

    function automatic int pending();
        return data_q.size() + mcf_q.size() + rx_q.size() + int'(n_pend || cyc < p_end);
    endfunction

    always @(posedge clk)
        cyc <= cyc + 1;

    // Outputs are settled at the falling edge
    always @(negedge clk) begin : check
        logic [32:0] exp;
        int          due;
        if (rst_n) begin
            if (m_tx_valid && m_tx_ready) begin
                if (!in_frame)
                    in_mcf = m_tx_data == 32'h0180_c200;  // Pause frame destination
                if ((in_mcf ? mcf_q.size() : data_q.size()) == 0) begin
                    errors++;
                    $display("m_tx beat %h transferred with no frame expected", m_tx_data);
                end else begin
                    if (in_mcf)
                        exp = mcf_q.pop_front();
                    else
                        exp = data_q.pop_front();
                    compare("m_tx_data", exp[31:0], m_tx_data);
                    compare("m_tx_last", exp[32], m_tx_last);
                end
                in_frame = !m_tx_last;
            end
            if (m_rx_valid) begin
                if (rx_q.size() == 0) begin
                    errors++;
                    $display("m_rx beat %h appeared with none expected", m_rx_data);
                end else begin
                    exp = rx_q.pop_front();
                    due = rx_cyc_q.pop_front();
                    compare("m_rx_data", exp[31:0], m_rx_data);
                    compare("m_rx_last", exp[32], m_rx_last);
                    if (due != cyc) begin
                        errors++;
                        $display("m_rx beat arrived at cycle %0d, due at %0d", cyc, due);
                    end
                end
            end else if (rx_q.size() > 0 && rx_cyc_q[0] <= cyc) begin
                errors++;
                $display("m_rx beat %h missing at cycle %0d", rx_q[0][31:0], cyc);
                exp = rx_q.pop_front();
                due = rx_cyc_q.pop_front();
            end
            if (n_pend && cyc >= n_start) begin
                p_start = n_start;
                p_end   = n_end;
                n_pend  = 0;
            end
            compare("rx_lfc_req", cyc >= p_start && cyc < p_end, rx_lfc_req);
            if (hold_en) begin
                compare("s_tx_ready", 0, s_tx_ready);
                compare("m_tx_valid", 0, m_tx_valid);
                compare("tx_pause_ack", 1, tx_pause_ack);
            end
            cnt[0] = cnt[0] + stat_tx_lfc_xoff;
            cnt[1] = cnt[1] + stat_tx_lfc_xon;
            cnt[2] = cnt[2] + stat_tx_mcf;
            cnt[3] = cnt[3] + stat_rx_mcf;
        end
    end

endmodule

// ==== tests/tb_mac_ctrl.sv ====
// Testbench top with clock, reset, frame stimulus, reference pause frame and DUT instance
`timescale 1ns/1ps

module tb_mac_ctrl;

    localparam logic [47:0] LOCAL_MAC = 48'h0a_1b_2c_3d_4e_5f;
    localparam int          QUANTUM   = 512 / 32;  // Cycles per pause quantum
    localparam int          TIMEOUT   = 3000;

    typedef logic [14:0][31:0] mcf_t;

    logic        clk = 0;
    logic        rst_n = 0;
    logic [31:0] s_tx_data = 0;
    logic [31:0] rx_data = 0;
    logic        s_tx_valid = 0, s_tx_last = 0, m_tx_ready = 0;
    logic        rx_valid = 0, rx_last = 0, tx_lfc_req = 0, lfc_pause_en = 0;
    logic        cfg_tx_lfc_en = 1, cfg_rx_lfc_en = 1, cfg_mcf_rx_forward = 0;
    logic [15:0] cfg_tx_lfc_quanta = 16'h1234;
    logic [15:0] cfg_tx_lfc_refresh = 16'hffff;  // Long enough to never fire
    wire  logic [31:0] m_tx_data, m_rx_data;
    wire  logic        s_tx_ready, m_tx_valid, m_tx_last, m_rx_valid, m_rx_last;
    wire  logic        rx_lfc_req, tx_pause_ack, stat_tx_mcf, stat_rx_mcf;
    wire  logic        stat_tx_lfc_xon, stat_tx_lfc_xoff;

    integer seed = 32'hd8efc327;
    bit     rand_ready = 0;
    int     test_no = 0;
    int     failed_tests = 0;
    int     err_mark = 0;

    mac_ctrl_top #(.DATA_W(32), .LOCAL_MAC(LOCAL_MAC)) i_mac_ctrl_top (.*);

    mac_ctrl_checker i_checker (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            #1 m_tx_ready = rand_ready ? ($random(seed) % 2 == 0) : 1'b1;
        end
    end

    // Expected words of a pause frame sent from LOCAL_MAC
    function automatic mcf_t build_mcf(input logic [15:0] quanta);
        mcf_t f;
        f = '0;
        f[0] = 32'h0180_c200;
        f[1] = {16'h0001, LOCAL_MAC[47:32]};
        f[2] = LOCAL_MAC[31:0];
        f[3] = {16'h8808, 16'h0001};
        f[4] = {quanta, 16'h0000};
        return f;
    endfunction

    task automatic abort(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic push_mcf(input logic [15:0] quanta);
        mcf_t f;
        f = build_mcf(quanta);
        for (int i = 0; i < 15; i++)
            i_checker.expect_tx(1, {i == 14, f[i]});
    endtask

    // Word 0 carries a tag so data never looks like a pause frame
    task automatic send_tx_frame(input int len, input int tag);
        int t;
        bit done;
        for (int i = 0; i < len; i++) begin
            s_tx_data  = (i == 0) ? {16'hda7a, 16'(tag)} : $random(seed);
            s_tx_last  = i == len - 1;
            s_tx_valid = 1;
            i_checker.expect_tx(0, {s_tx_last, s_tx_data});
            t    = 0;
            done = 0;
            while (!done) begin
                @(negedge clk);
                done = s_tx_ready;
                step();
                t++;
                if (t > TIMEOUT)
                    abort("s_tx_ready");
            end
        end
        s_tx_valid = 0;
    endtask

    // Negative pause_len means the frame starts no pause
    task automatic send_rx_frame(input mcf_t f, input bit forwarded, input int pause_len);
        for (int i = 0; i < 15; i++) begin
            rx_data  = f[i];
            rx_valid = 1;
            rx_last  = i == 14;
            if (forwarded)
                i_checker.expect_rx({rx_last, rx_data});
            if (rx_last && pause_len >= 0)
                i_checker.expect_pause(pause_len);
            step();
        end
        rx_valid = 0;
        rx_last  = 0;
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (i_checker.pending() > 0) begin
            step();
            t++;
            if (t > TIMEOUT)
                abort("expected frames and pause window");
        end
    endtask

    task automatic end_test(input string name);
        test_no++;
        if (i_checker.errors == err_mark) begin
            $display("test %0d %s: ok", test_no, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_no, name, i_checker.errors - err_mark);
        end
        err_mark = i_checker.errors;
    endtask

    initial begin
        mcf_t f;
        int   t;
        repeat (16) @(posedge clk);
        #1 rst_n = 1;
        step();
        rand_ready = 1;

        for (int n = 0; n < 20; n++)
            send_tx_frame(1 + $unsigned($random(seed)) % 8, n);
        wait_idle();
        i_checker.expect_counts(0, 0, 0, 0);
        end_test("transmit pass-through");

        push_mcf(cfg_tx_lfc_quanta);
        tx_lfc_req = 1;
        wait_idle();
        i_checker.expect_counts(1, 0, 1, 0);
        push_mcf(16'h0000);
        tx_lfc_req = 0;
        wait_idle();
        i_checker.expect_counts(0, 1, 1, 0);
        end_test("xoff and xon generation");

        cfg_tx_lfc_refresh = 16'd8;  // 128 cycles between XOFF frames
        push_mcf(cfg_tx_lfc_quanta);
        push_mcf(cfg_tx_lfc_quanta);
        tx_lfc_req = 1;
        fork
            for (int n = 0; n < 16; n++)
                send_tx_frame(1 + $unsigned($random(seed)) % 8, 50 + n);
            begin
                t = 0;
                while (i_checker.mcf_left() > 0) begin
                    step();
                    t++;
                    if (t > TIMEOUT)
                        abort("refreshed xoff frames");
                end
                push_mcf(16'h0000);
                tx_lfc_req = 0;
            end
        join
        wait_idle();
        i_checker.expect_counts(2, 1, 3, 0);
        cfg_tx_lfc_refresh = 16'hffff;
        end_test("xoff refresh");

        send_rx_frame(build_mcf(16'd3), 0, 3 * QUANTUM);
        wait_idle();
        cfg_mcf_rx_forward = 1;
        send_rx_frame(build_mcf(16'd3), 1, 3 * QUANTUM);
        wait_idle();
        cfg_mcf_rx_forward = 0;
        i_checker.expect_counts(0, 0, 0, 2);
        end_test("receive pause frame");

        f = build_mcf(16'd5);
        f[3] = {16'h8808, 16'h0002};  // Unknown opcode
        send_rx_frame(f, 1, -1);
        f[3] = {16'h8808, 16'h0101};  // PFC
        send_rx_frame(f, 1, -1);
        f[3] = {16'h0800, 16'h0001};
        send_rx_frame(f, 1, -1);
        wait_idle();
        i_checker.expect_counts(0, 0, 0, 0);
        end_test("receive non-control frames");

        lfc_pause_en = 1;
        send_rx_frame(build_mcf(16'd8), 0, 8 * QUANTUM);
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT)
                abort("tx_pause_ack");
        end while (!tx_pause_ack);
        step();
        i_checker.hold_en = 1;
        fork
            for (int n = 0; n < 3; n++)
                send_tx_frame(2 + n, 100 + n);
            begin
                repeat (40) step();
                i_checker.hold_en = 0;
                send_rx_frame(build_mcf(16'd0), 0, 0);  // XON ends the pause
            end
        join
        wait_idle();
        lfc_pause_en = 0;
        i_checker.expect_counts(0, 0, 0, 2);
        end_test("pause loop");

        $display("%0d tests, %0d failed, %0d errors", test_no, failed_tests, i_checker.errors);
        if (failed_tests == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== mac_ctrl.f ====
verilog/mac_ctrl_pkg.sv
verilog/mcf_rx_parser.sv
verilog/lfc_rx_timer.sv
verilog/lfc_tx_gen.sv
verilog/mcf_tx_mux.sv
verilog/mac_ctrl_top.sv
tests/mac_ctrl_checker.sv
tests/tb_mac_ctrl.sv
